// File: include/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Fetch block geometry
`define FETCH_ADDR_W    32
`define FETCH_LANES     4

// Predictor table sizes
`define BTB_ENTRIES     16
`define PHT_ENTRIES     64

`define FETCH_RESET_PC  32'h0000_1000

`endif

// File: hdl/fetch_pkg.sv
`default_nettype none
`include "fetch_cfg.svh"

package fetch_pkg;

    localparam int unsigned LANE_W = $clog2(`FETCH_LANES);
    localparam int unsigned OFS_W  = LANE_W + 2;    // Byte offset inside one block

    typedef logic [`FETCH_ADDR_W-1:0]   addr_t;
    typedef logic [`FETCH_LANES-1:0]    lane_mask_t;
    typedef logic [LANE_W-1:0]          lane_idx_t;

    // Lane 0 in the low word
    typedef logic [`FETCH_LANES*32-1:0] block_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,        // inst_req_o high
        WAIT_DATA
    } fetch_state_e;

endpackage

`default_nettype wire

// File: hdl/bpred_pkg.sv
`default_nettype none
`include "fetch_cfg.svh"

package bpred_pkg;

    localparam int unsigned BTB_IDX_W = $clog2(`BTB_ENTRIES);
    localparam int unsigned BTB_TAG_W = `FETCH_ADDR_W - BTB_IDX_W - fetch_pkg::OFS_W;

    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_e;

    typedef struct packed {
        logic                   valid;
        logic [BTB_TAG_W-1:0]   tag;
        fetch_pkg::lane_idx_t   lane;     // First predicted branch in the block
        fetch_pkg::addr_t       target;
    } btb_entry_t;

    // Saturating step
    function automatic ctr_e ctr_next(input ctr_e cur, input logic taken);
        ctr_e nxt;
        nxt = cur;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
            default:   nxt = WEAK_NT;
        endcase
        return nxt;
    endfunction

endpackage

`default_nettype wire

// File: hdl/pc_register.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module pc_register (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire                         req_accept_i,
    input  wire                         exc_valid_i,
    input  wire fetch_pkg::addr_t       exc_pc_i,
    input  wire                         br_mispredict_i,
    input  wire fetch_pkg::addr_t       br_target_i,
    input  wire                         btb_hit_i,
    input  wire fetch_pkg::lane_idx_t   btb_lane_i,
    input  wire fetch_pkg::addr_t       btb_target_i,
    input  wire fetch_pkg::lane_mask_t  pht_taken_i,
    output fetch_pkg::addr_t            fetch_pc_o,
    output fetch_pkg::lane_mask_t       fetch_lane_en_o,
    output logic                        pred_taken_o,
    output fetch_pkg::addr_t            pred_target_o,
    output logic                        flush_o
);

    localparam int unsigned LANE_W = fetch_pkg::LANE_W;
    localparam int unsigned OFS_W  = fetch_pkg::OFS_W;

    fetch_pkg::addr_t       pc_q;
    fetch_pkg::addr_t       seq_pc;
    fetch_pkg::addr_t       redirect_pc;
    fetch_pkg::lane_mask_t  from_ofs;
    fetch_pkg::lane_mask_t  upto_br;

    //////////////////////////////////////////////////
    // Lane enables and prediction

    assign from_ofs = {`FETCH_LANES{1'b1}} << pc_q[2 +: LANE_W];
    assign upto_br  = {`FETCH_LANES{1'b1}} >> (`FETCH_LANES - 1 - btb_lane_i);

    // Only a hit on a live lane counts
    assign pred_taken_o = btb_hit_i && from_ofs[btb_lane_i] && pht_taken_i[btb_lane_i];

    assign fetch_lane_en_o = pred_taken_o ? (from_ofs & upto_br) : from_ofs;

    assign seq_pc        = {pc_q[`FETCH_ADDR_W-1:OFS_W] + 1'b1, {OFS_W{1'b0}}};
    assign pred_target_o = pred_taken_o ? btb_target_i : seq_pc;

    //////////////////////////////////////////////////
    // Redirect and PC state

    assign flush_o     = exc_valid_i | br_mispredict_i;
    assign redirect_pc = exc_valid_i ? exc_pc_i : br_target_i;  // Exception first

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (flush_o) begin
            pc_q <= redirect_pc;
        end else if (req_accept_i) begin
            pc_q <= pred_target_o;
        end
    end

    assign fetch_pc_o = pc_q;

endmodule

`default_nettype wire

// File: hdl/branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module branch_target_buffer (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire fetch_pkg::addr_t       fetch_pc_i,
    input  wire                         upd_valid_i,
    input  wire fetch_pkg::addr_t       upd_pc_i,
    input  wire                         upd_taken_i,
    input  wire fetch_pkg::addr_t       upd_target_i,
    output logic                        hit_o,
    output fetch_pkg::lane_idx_t        lane_o,
    output fetch_pkg::addr_t            target_o
);

    localparam int unsigned OFS_W = fetch_pkg::OFS_W;
    localparam int unsigned IDX_W = bpred_pkg::BTB_IDX_W;
    localparam int unsigned TAG_W = bpred_pkg::BTB_TAG_W;

    bpred_pkg::btb_entry_t  entry_q [`BTB_ENTRIES];
    bpred_pkg::btb_entry_t  rd_entry;
    bpred_pkg::btb_entry_t  upd_entry;
    bpred_pkg::btb_entry_t  upd_old;
    logic [IDX_W-1:0]       rd_idx;
    logic [TAG_W-1:0]       rd_tag;
    logic [IDX_W-1:0]       upd_idx;
    logic [TAG_W-1:0]       upd_tag;
    fetch_pkg::lane_idx_t   upd_lane;
    logic                   upd_match;

    //////////////////////////////////////////////////
    // Lookup

    assign rd_idx   = fetch_pc_i[OFS_W +: IDX_W];
    assign rd_tag   = fetch_pc_i[`FETCH_ADDR_W-1 -: TAG_W];
    assign rd_entry = entry_q[rd_idx];

    assign hit_o    = rd_entry.valid && (rd_entry.tag == rd_tag);
    assign lane_o   = rd_entry.lane;
    assign target_o = rd_entry.target;

    //////////////////////////////////////////////////
    // Update from branch resolution

    assign upd_idx  = upd_pc_i[OFS_W +: IDX_W];
    assign upd_tag  = upd_pc_i[`FETCH_ADDR_W-1 -: TAG_W];
    assign upd_lane = upd_pc_i[2 +: fetch_pkg::LANE_W];
    assign upd_old  = entry_q[upd_idx];

    // Same block and same branch
    assign upd_match = upd_old.valid && (upd_old.tag == upd_tag) && (upd_old.lane == upd_lane);

    always_comb begin
        upd_entry        = '0;
        upd_entry.valid  = 1'b1;
        upd_entry.tag    = upd_tag;
        upd_entry.lane   = upd_lane;
        upd_entry.target = upd_target_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                entry_q[i] <= '0;
            end
        end else if (upd_valid_i) begin
            if (upd_taken_i) begin
                entry_q[upd_idx] <= upd_entry;
            end else if (upd_match) begin
                entry_q[upd_idx].valid <= 1'b0;     // Branch went not taken
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/pattern_history_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module pattern_history_table (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire fetch_pkg::addr_t       fetch_pc_i,
    input  wire                         upd_valid_i,
    input  wire fetch_pkg::addr_t       upd_pc_i,
    input  wire                         upd_taken_i,
    output fetch_pkg::lane_mask_t       taken_o
);

    localparam int unsigned LANE_W = fetch_pkg::LANE_W;
    localparam int unsigned OFS_W  = fetch_pkg::OFS_W;
    localparam int unsigned IDX_W  = $clog2(`PHT_ENTRIES);

    bpred_pkg::ctr_e    ctr_q [`PHT_ENTRIES];
    logic [IDX_W-1:0]   upd_idx;

    //////////////////////////////////////////////////
    // Four-lane read with one counter per word

    for (genvar l = 0; l < `FETCH_LANES; l++) begin : g_lane
        logic [IDX_W-1:0] rd_idx;

        assign rd_idx = {fetch_pc_i[OFS_W +: IDX_W-LANE_W], LANE_W'(l)};

        assign taken_o[l] = (ctr_q[rd_idx] == bpred_pkg::WEAK_T) ||
                            (ctr_q[rd_idx] == bpred_pkg::STRONG_T);
    end

    //////////////////////////////////////////////////
    // Resolve update

    assign upd_idx = upd_pc_i[2 +: IDX_W];     // Word address

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `PHT_ENTRIES; i++) begin
                ctr_q[i] <= bpred_pkg::WEAK_NT;
            end
        end else if (upd_valid_i) begin
            ctr_q[upd_idx] <= bpred_pkg::ctr_next(ctr_q[upd_idx], upd_taken_i);
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_cfg.svh"

module fetch_ctrl (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire fetch_pkg::addr_t       fetch_pc_i,
    input  wire fetch_pkg::lane_mask_t  fetch_lane_en_i,
    input  wire                         pred_taken_i,
    input  wire fetch_pkg::addr_t       pred_target_i,
    input  wire                         flush_i,
    input  wire                         inst_index_ok_i,
    input  wire                         inst_data_ok_i,
    input  wire fetch_pkg::block_t      inst_rdata_i,
    input  wire                         iq_ready_i,
    output logic                        req_accept_o,
    output logic                        inst_req_o,
    output fetch_pkg::addr_t            inst_index_o,
    output logic                        iq_valid_o,
    output fetch_pkg::addr_t            iq_pc_o,
    output fetch_pkg::block_t           iq_inst_o,
    output fetch_pkg::lane_mask_t       iq_lane_en_o,
    output logic                        iq_pred_taken_o,
    output fetch_pkg::addr_t            iq_pred_target_o
);

    localparam int unsigned OFS_W = fetch_pkg::OFS_W;

    fetch_pkg::fetch_state_e    state_q;
    fetch_pkg::fetch_state_e    state_d;
    logic                       drop_q;     // Response of a flushed request
    logic                       data_fire;
    logic                       iq_fire;
    logic                       can_issue;

    // Block in flight
    fetch_pkg::addr_t           meta_pc_q;
    fetch_pkg::lane_mask_t      meta_lane_en_q;
    logic                       meta_pred_taken_q;
    fetch_pkg::addr_t           meta_pred_target_q;

    // Output buffer
    logic                       buf_valid_q;
    fetch_pkg::addr_t           buf_pc_q;
    fetch_pkg::block_t          buf_inst_q;
    fetch_pkg::lane_mask_t      buf_lane_en_q;
    logic                       buf_pred_taken_q;
    fetch_pkg::addr_t           buf_pred_target_q;

    //////////////////////////////////////////////////
    // Cache request FSM

    assign inst_req_o   = (state_q == fetch_pkg::REQ) && !flush_i;  // Withdrawn on flush
    assign inst_index_o = {fetch_pc_i[`FETCH_ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
    assign req_accept_o = inst_req_o && inst_index_ok_i;

    assign iq_fire   = buf_valid_q && iq_ready_i;
    assign can_issue = !buf_valid_q || iq_ready_i;
    assign data_fire = (state_q == fetch_pkg::WAIT_DATA) && inst_data_ok_i && !drop_q && !flush_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IDLE: begin
                if (can_issue) begin
                    state_d = fetch_pkg::REQ;
                end
            end
            fetch_pkg::REQ: begin
                if (req_accept_o) begin
                    state_d = fetch_pkg::WAIT_DATA;
                end
            end
            fetch_pkg::WAIT_DATA: begin
                if (inst_data_ok_i) begin
                    state_d = fetch_pkg::IDLE;
                end
            end
            default: state_d = fetch_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= fetch_pkg::IDLE;
            drop_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == fetch_pkg::WAIT_DATA) begin
                if (inst_data_ok_i) begin
                    drop_q <= 1'b0;
                end else if (flush_i) begin
                    drop_q <= 1'b1;
                end
            end
        end
    end

    // Prediction travels with the request
    always_ff @(posedge clk_i) begin
        if (req_accept_o) begin
            meta_pc_q          <= fetch_pc_i;
            meta_lane_en_q     <= fetch_lane_en_i;
            meta_pred_taken_q  <= pred_taken_i;
            meta_pred_target_q <= pred_target_i;
        end
    end

    //////////////////////////////////////////////////
    // Instruction queue buffer

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            buf_valid_q <= 1'b0;
        end else if (flush_i) begin
            buf_valid_q <= 1'b0;
        end else if (data_fire) begin
            buf_valid_q <= 1'b1;
        end else if (iq_fire) begin
            buf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_fire) begin
            buf_pc_q          <= meta_pc_q;
            buf_inst_q        <= inst_rdata_i;
            buf_lane_en_q     <= meta_lane_en_q;
            buf_pred_taken_q  <= meta_pred_taken_q;
            buf_pred_target_q <= meta_pred_target_q;
        end
    end

    assign iq_valid_o       = buf_valid_q;
    assign iq_pc_o          = buf_pc_q;
    assign iq_inst_o        = buf_inst_q;
    assign iq_lane_en_o     = buf_lane_en_q;
    assign iq_pred_taken_o  = buf_pred_taken_q;
    assign iq_pred_target_o = buf_pred_target_q;

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    // Instruction cache
    output logic                        inst_req_o,
    output fetch_pkg::addr_t            inst_index_o,
    input  wire                         inst_index_ok_i,
    input  wire                         inst_data_ok_i,
    input  wire fetch_pkg::block_t      inst_rdata_i,
    // Instruction queue
    output logic                        iq_valid_o,
    input  wire                         iq_ready_i,
    output fetch_pkg::addr_t            iq_pc_o,
    output fetch_pkg::block_t           iq_inst_o,
    output fetch_pkg::lane_mask_t       iq_lane_en_o,
    output logic                        iq_pred_taken_o,
    output fetch_pkg::addr_t            iq_pred_target_o,
    // Branch resolution
    input  wire                         br_update_valid_i,
    input  wire fetch_pkg::addr_t       br_pc_i,
    input  wire                         br_taken_i,
    input  wire fetch_pkg::addr_t       br_target_i,
    input  wire                         br_mispredict_i,
    // Exception redirect
    input  wire                         exc_valid_i,
    input  wire fetch_pkg::addr_t       exc_pc_i
);

    fetch_pkg::addr_t       fetch_pc;
    fetch_pkg::lane_mask_t  fetch_lane_en;
    logic                   pred_taken;
    fetch_pkg::addr_t       pred_target;
    logic                   flush;
    logic                   req_accept;
    logic                   btb_hit;
    fetch_pkg::lane_idx_t   btb_lane;
    fetch_pkg::addr_t       btb_target;
    fetch_pkg::lane_mask_t  pht_taken;

    pc_register u_pc_register (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .req_accept_i    (req_accept),
        .exc_valid_i     (exc_valid_i),
        .exc_pc_i        (exc_pc_i),
        .br_mispredict_i (br_mispredict_i),
        .br_target_i     (br_target_i),
        .btb_hit_i       (btb_hit),
        .btb_lane_i      (btb_lane),
        .btb_target_i    (btb_target),
        .pht_taken_i     (pht_taken),
        .fetch_pc_o      (fetch_pc),
        .fetch_lane_en_o (fetch_lane_en),
        .pred_taken_o    (pred_taken),
        .pred_target_o   (pred_target),
        .flush_o         (flush)
    );

    branch_target_buffer u_branch_target_buffer (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .fetch_pc_i   (fetch_pc),
        .upd_valid_i  (br_update_valid_i),
        .upd_pc_i     (br_pc_i),
        .upd_taken_i  (br_taken_i),
        .upd_target_i (br_target_i),
        .hit_o        (btb_hit),
        .lane_o       (btb_lane),
        .target_o     (btb_target)
    );

    pattern_history_table u_pattern_history_table (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .fetch_pc_i  (fetch_pc),
        .upd_valid_i (br_update_valid_i),
        .upd_pc_i    (br_pc_i),
        .upd_taken_i (br_taken_i),
        .taken_o     (pht_taken)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .fetch_pc_i       (fetch_pc),
        .fetch_lane_en_i  (fetch_lane_en),
        .pred_taken_i     (pred_taken),
        .pred_target_i    (pred_target),
        .flush_i          (flush),
        .inst_index_ok_i  (inst_index_ok_i),
        .inst_data_ok_i   (inst_data_ok_i),
        .inst_rdata_i     (inst_rdata_i),
        .iq_ready_i       (iq_ready_i),
        .req_accept_o     (req_accept),
        .inst_req_o       (inst_req_o),
        .inst_index_o     (inst_index_o),
        .iq_valid_o       (iq_valid_o),
        .iq_pc_o          (iq_pc_o),
        .iq_inst_o        (iq_inst_o),
        .iq_lane_en_o     (iq_lane_en_o),
        .iq_pred_taken_o  (iq_pred_taken_o),
        .iq_pred_target_o (iq_pred_target_o)
    );

endmodule

`default_nettype wire

// File: sim/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
    input wire                          clk_i,
    input wire                          arst_n_i,
    input wire                          inst_req_i,
    input wire fetch_pkg::addr_t        inst_index_i,
    input wire                          inst_index_ok_i,
    input wire                          iq_valid_i,
    input wire                          iq_ready_i,
    input wire fetch_pkg::addr_t        iq_pc_i,
    input wire fetch_pkg::block_t       iq_inst_i,
    input wire fetch_pkg::lane_mask_t   iq_lane_en_i,
    input wire                          iq_pred_taken_i,
    input wire fetch_pkg::addr_t        iq_pred_target_i,
    input wire                          redirect_i
);

    int assert_fails = 0;   // Read by the testbench

    ///////////////////////////////////////////////////
    // Cache request rules

    a_index_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        inst_req_i && !inst_index_ok_i |=> $stable(inst_index_i))
        else begin
            $error("inst_index_o changed before acceptance");
            assert_fails++;
        end

    a_index_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        inst_req_i |-> inst_index_i[3:0] == 4'h0)
        else begin
            $error("inst_index_o not block aligned");
            assert_fails++;
        end

    ///////////////////////////////////////////////////
    // Queue side

    a_iq_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        iq_valid_i && !iq_ready_i && !redirect_i |=>
            iq_valid_i && $stable(iq_pc_i) && $stable(iq_inst_i) && $stable(iq_lane_en_i)
            && $stable(iq_pred_taken_i) && $stable(iq_pred_target_i))
        else begin
            $error("queue outputs moved under back-pressure");
            assert_fails++;
        end

    a_iq_reset: assert property (@(posedge clk_i) !arst_n_i |-> !iq_valid_i)
        else begin
            $error("iq_valid_o high during reset");
            assert_fails++;
        end

endmodule

bind fetch_stage fetch_checker i_fetch_checker (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .inst_req_i       (inst_req_o),
    .inst_index_i     (inst_index_o),
    .inst_index_ok_i  (inst_index_ok_i),
    .iq_valid_i       (iq_valid_o),
    .iq_ready_i       (iq_ready_i),
    .iq_pc_i          (iq_pc_o),
    .iq_inst_i        (iq_inst_o),
    .iq_lane_en_i     (iq_lane_en_o),
    .iq_pred_taken_i  (iq_pred_taken_o),
    .iq_pred_target_i (iq_pred_target_o),
    .redirect_i       (exc_valid_i | br_mispredict_i)
);

`default_nettype wire

// File: sim/tb_fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_stage;

    localparam int NUM_TESTS   = 10;
    localparam int BLOCKS      = 3;     // Queue blocks checked per test
    localparam int CYCLE_LIMIT = NUM_TESTS * 100 + 20;

    typedef struct {
        string       name;
        int          upd_cnt;
        logic [31:0] upd_pc;
        logic        upd_taken;
        logic [31:0] upd_target;
        logic        exc;
        logic        misp;
        logic [31:0] exc_pc;
        logic [31:0] misp_target;
        logic        wait_busy;     // Redirect while a response is outstanding
        int          stall;
        logic [31:0] exp_pc;
        logic [3:0]  exp_lanes;
        logic        exp_taken;
        logic [31:0] exp_target;
    } test_t;

    logic clk_i = 1'b0;
    logic arst_n_i;
    logic inst_index_ok_i;
    logic inst_data_ok_i;
    logic iq_ready_i;
    logic [127:0] inst_rdata_i;
    logic br_update_valid_i;
    logic br_taken_i;
    logic br_mispredict_i;
    logic exc_valid_i;
    logic [31:0] br_pc_i;
    logic [31:0] br_target_i;
    logic [31:0] exc_pc_i;
    wire inst_req_o;
    wire iq_valid_o;
    wire iq_pred_taken_o;
    wire [31:0] inst_index_o;
    wire [31:0] iq_pc_o;
    wire [31:0] iq_pred_target_o;
    wire [127:0] iq_inst_o;
    wire [3:0] iq_lane_en_o;

    test_t tests [NUM_TESTS];
    integer seed;
    int cycle_cnt = 0;
    int err_cnt = 0;
    int test_errs;
    int pass_tests = 0;
    int fail_tests = 0;

    // Reference predictor state
    logic        m_valid [16];
    logic [23:0] m_tag [16];
    logic [1:0]  m_lane [16];
    logic [31:0] m_tgt [16];
    int          m_ctr [64];

    // Cache model state
    logic        busy = 1'b0;
    logic        safe_flush = 1'b0;
    int          lat = 0;
    int          acc_wait = 0;
    logic [31:0] req_addr;

    fetch_stage i_dut (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    ///////////////////////////////////////////////////
    // Cache model

    always @(negedge clk_i) begin
        inst_data_ok_i = 1'b0;
        if (busy) begin
            if (lat <= 1) begin
                inst_data_ok_i = 1'b1;
                inst_rdata_i = {req_addr + 32'd12, req_addr + 32'd8, req_addr + 32'd4, req_addr};
                busy = 1'b0;
            end else begin
                lat = lat - 1;
            end
        end
        inst_index_ok_i = !busy && (acc_wait == 0);
        #1;
        if (inst_req_o && inst_index_ok_i) begin
            req_addr = inst_index_o;
            busy = 1'b1;
            lat = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
            acc_wait = ($random(seed) & 32'h7fff_ffff) % 3;
        end else if (inst_req_o && acc_wait > 0) begin
            acc_wait = acc_wait - 1;
        end
        safe_flush = busy && (lat >= 2);
    end

    ///////////////////////////////////////////////////
    // Reference model

    task automatic apply_resolve(input logic [31:0] pc, input logic taken,
                                 input logic [31:0] target);
        int idx;
        int ci;
        idx = pc[7:4];
        ci = pc[7:2];
        if (taken) begin
            m_valid[idx] = 1'b1;
            m_tag[idx] = pc[31:8];
            m_lane[idx] = pc[3:2];
            m_tgt[idx] = target;
        end else if (m_valid[idx] && m_tag[idx] == pc[31:8] && m_lane[idx] == pc[3:2]) begin
            m_valid[idx] = 1'b0;
        end
        if (taken) m_ctr[ci] = (m_ctr[ci] == 3) ? 3 : m_ctr[ci] + 1;
        else       m_ctr[ci] = (m_ctr[ci] == 0) ? 0 : m_ctr[ci] - 1;
    endtask

    task automatic predict_block(input logic [31:0] pc, output logic [3:0] lanes,
                                 output logic taken, output logic [31:0] target);
        int ofs;
        int idx;
        int bl;
        ofs = pc[3:2];
        idx = pc[7:4];
        bl = m_lane[idx];
        taken = m_valid[idx] && m_tag[idx] == pc[31:8] && bl >= ofs
                && m_ctr[{pc[7:4], m_lane[idx]}] >= 2;
        lanes = 4'b0000;
        for (int l = 0; l < 4; l++) begin
            if (l >= ofs && (!taken || l <= bl)) lanes[l] = 1'b1;
        end
        target = taken ? m_tgt[idx] : {pc[31:4] + 28'd1, 4'h0};
    endtask

    task automatic check_block(input string name, input logic [31:0] pc, input logic [3:0] lanes,
                               input logic taken, input logic [31:0] target);
        logic [31:0] base;
        base = {pc[31:4], 4'h0};
        assert (iq_pc_o == pc) else begin
            $display("FAIL %s pc expected %h actual %h", name, pc, iq_pc_o);
            test_errs++;
        end
        assert (iq_lane_en_o == lanes) else begin
            $display("FAIL %s lanes expected %b actual %b", name, lanes, iq_lane_en_o);
            test_errs++;
        end
        assert (iq_pred_taken_o == taken) else begin
            $display("FAIL %s taken expected %b actual %b", name, taken, iq_pred_taken_o);
            test_errs++;
        end
        assert (iq_pred_target_o == target) else begin
            $display("FAIL %s target expected %h actual %h", name, target, iq_pred_target_o);
            test_errs++;
        end
        for (int w = 0; w < 4; w++) begin
            assert (iq_inst_o[w*32 +: 32] == base + 32'(4 * w)) else begin
                $display("FAIL %s word %0d expected %h actual %h", name, w,
                         base + 32'(4 * w), iq_inst_o[w*32 +: 32]);
                test_errs++;
            end
        end
    endtask

    ///////////////////////////////////////////////////
    // Test sequence

    function automatic test_t make_test(string name, int upd_cnt, logic [31:0] upd_pc,
                                        logic upd_taken, logic exc, logic misp,
                                        logic [31:0] exc_pc, logic [31:0] misp_target,
                                        logic wait_busy, int stall, logic [31:0] exp_pc,
                                        logic [3:0] exp_lanes, logic exp_taken,
                                        logic [31:0] exp_target);
        test_t t;
        t = '{name, upd_cnt, upd_pc, upd_taken, 32'h0000_3800, exc, misp, exc_pc, misp_target,
              wait_busy, stall, exp_pc, exp_lanes, exp_taken, exp_target};
        return t;
    endfunction

    task automatic run_test(input test_t t);
        logic [31:0] pc;
        logic [3:0]  lanes;
        logic        taken;
        logic [31:0] target;
        int          got;
        int          stall_left;
        test_errs = 0;
        for (int k = 0; k < t.upd_cnt; k++) begin
            @(negedge clk_i);
            br_update_valid_i = 1'b1;
            br_pc_i = t.upd_pc;
            br_taken_i = t.upd_taken;
            br_target_i = t.upd_target;
            apply_resolve(t.upd_pc, t.upd_taken, t.upd_target);
        end
        if (t.upd_cnt > 0) begin
            @(negedge clk_i);
            br_update_valid_i = 1'b0;
        end
        if (t.exc || t.misp) begin
            if (t.wait_busy) begin
                do @(negedge clk_i); while (!safe_flush);
            end else begin
                @(negedge clk_i);
            end
            exc_valid_i = t.exc;
            exc_pc_i = t.exc_pc;
            br_mispredict_i = t.misp;
            br_target_i = t.misp_target;
            @(negedge clk_i);
            exc_valid_i = 1'b0;
            br_mispredict_i = 1'b0;
        end
        got = 0;
        stall_left = t.stall;
        pc = t.exp_pc;
        while (got < BLOCKS) begin
            @(negedge clk_i);
            iq_ready_i = !(iq_valid_o && stall_left > 0);
            if (!iq_ready_i) stall_left--;
            if (iq_valid_o && iq_ready_i) begin
                if (got == 0) begin
                    check_block(t.name, pc, t.exp_lanes, t.exp_taken, t.exp_target);
                    pc = t.exp_target;
                end else begin
                    predict_block(pc, lanes, taken, target);
                    check_block(t.name, pc, lanes, taken, target);
                    pc = target;
                end
                got++;
            end
        end
        err_cnt += test_errs;
        if (test_errs == 0) pass_tests++;
        else fail_tests++;
        $display("Test %-18s %s", t.name, (test_errs == 0) ? "passed" : "had errors");
    endtask

    initial begin
        seed = 32'hc5fa_364f;
        arst_n_i = 1'b0;
        inst_index_ok_i = 1'b0;
        inst_data_ok_i = 1'b0;
        inst_rdata_i = '0;
        iq_ready_i = 1'b1;
        br_update_valid_i = 1'b0;
        br_pc_i = '0;
        br_taken_i = 1'b0;
        br_target_i = '0;
        br_mispredict_i = 1'b0;
        exc_valid_i = 1'b0;
        exc_pc_i = '0;
        for (int i = 0; i < 16; i++) m_valid[i] = 1'b0;
        for (int i = 0; i < 64; i++) m_ctr[i] = 1;    // WEAK_NT

        tests[0] = make_test("reset_sequential", 0, 0, 0, 0, 0, 0, 0, 0, 0,
                             32'h1000, 4'b1111, 0, 32'h1010);
        tests[1] = make_test("exc_unaligned", 0, 0, 0, 1, 0, 32'h2008, 0, 0, 0,
                             32'h2008, 4'b1100, 0, 32'h2010);
        tests[2] = make_test("exc_over_mispredict", 0, 0, 0, 1, 1, 32'h2408, 32'h5000, 0, 0,
                             32'h2408, 4'b1100, 0, 32'h2410);
        tests[3] = make_test("mispredict_redirect", 0, 0, 0, 0, 1, 0, 32'h4000, 0, 0,
                             32'h4000, 4'b1111, 0, 32'h4010);
        tests[4] = make_test("train_lane1", 1, 32'h3004, 1, 1, 0, 32'h3000, 0, 0, 0,
                             32'h3000, 4'b0011, 1, 32'h3800);
        tests[5] = make_test("second_taken", 1, 32'h3004, 1, 1, 0, 32'h3000, 0, 0, 0,
                             32'h3000, 4'b0011, 1, 32'h3800);
        tests[6] = make_test("not_taken_other_lane", 1, 32'h3008, 0, 1, 0, 32'h3000, 0, 0, 0,
                             32'h3000, 4'b0011, 1, 32'h3800);
        tests[7] = make_test("not_taken_same_lane", 1, 32'h3004, 0, 1, 0, 32'h3000, 0, 0, 0,
                             32'h3000, 4'b1111, 0, 32'h3010);
        tests[8] = make_test("flush_outstanding", 0, 0, 0, 1, 0, 32'h6000, 0, 1, 0,
                             32'h6000, 4'b1111, 0, 32'h6010);
        tests[9] = make_test("backpressure", 0, 0, 0, 1, 0, 32'h7004, 0, 0, 6,
                             32'h7004, 4'b1110, 0, 32'h7010);

        repeat (10) @(negedge clk_i);
        arst_n_i = 1'b1;

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(tests[i]);
        end

        $display("Tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 pass_tests, fail_tests, err_cnt, i_dut.i_fetch_checker.assert_fails);
        if (fail_tests == 0 && err_cnt == 0 && i_dut.i_fetch_checker.assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
hdl/fetch_pkg.sv
hdl/bpred_pkg.sv
hdl/pc_register.sv
hdl/branch_target_buffer.sv
hdl/pattern_history_table.sv
hdl/fetch_ctrl.sv
hdl/fetch_stage.sv
sim/fetch_checker.sv
sim/tb_fetch_stage.sv

// File: Makefile
# Verilator build and run for the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
FLIST     ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FLIST))
HDRS    := include/fetch_cfg.svh
SIM_BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(SIM_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(SIM_DIR) $(LOG)
